// File: fifo_pkg.sv
package fifo_pkg;

  // FIFO geometry
  localparam int DATA_WIDTH = 8;
  localparam int FIFO_DEPTH = 16;
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int PTR_WIDTH  = ADDR_WIDTH + 1;

  // Flag thresholds, compared against the occupancy seen by each side
  localparam int FIFO_AFULL  = FIFO_DEPTH - 2;
  localparam int FIFO_AEMPTY = 2;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // The top bit of a pointer is the wrap bit that tells full from empty
  typedef logic [PTR_WIDTH-1:0]  ptr_t;

  // One write into the storage array
  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } ram_wr_t;

  // One read request into the storage array
  typedef struct packed {
    logic  en;
    addr_t addr;
  } ram_rd_t;

  // Only one bit changes between neighbours, so a pointer can cross domains safely
  function automatic ptr_t bin2gray(input ptr_t bin);
    ptr_t gray;
    gray = bin ^ (bin >> 1);
    return gray;
  endfunction

endpackage

// File: dual_port_ram.sv
module dual_port_ram (
  input  logic              wr_clk,
  input  fifo_pkg::ram_wr_t wr,
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  fifo_pkg::ram_rd_t rd,
  output fifo_pkg::data_t   rd_data
);

  import fifo_pkg::*;

  data_t mem [FIFO_DEPTH];

  // Write port lives entirely in the write clock domain
  always_ff @(posedge wr_clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Registered read port
  // The word stays on rd_data until the next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd.en) begin
      rd_data <= mem[rd.addr];
    end
  end

endmodule

// File: gray_ptr_sync.sv
module gray_ptr_sync (
  input  logic           clk,
  input  logic           rst_n,
  input  fifo_pkg::ptr_t gray_in,
  output fifo_pkg::ptr_t bin_out
);

  import fifo_pkg::*;

  ptr_t gray_meta;
  ptr_t gray_sync;

  // Two flop synchronizer for a pointer that changes one bit at a time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_sync <= gray_meta;
    end
  end

  // Prefix XOR from the MSB down turns the Gray code back into binary
  always_comb begin
    bin_out[PTR_WIDTH-1] = gray_sync[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin_out[i] = bin_out[i+1] ^ gray_sync[i];
    end
  end

endmodule

// File: wr_ptr_ctrl.sv
module wr_ptr_ctrl (
  input  logic              wr_clk,
  input  logic              wr_rst_n,
  input  logic              wr_en,
  input  fifo_pkg::data_t   wr_data,
  input  fifo_pkg::ptr_t    rd_ptr_bin,
  output fifo_pkg::ptr_t    wr_ptr_gray,
  output fifo_pkg::ram_wr_t ram_wr,
  output logic              full,
  output logic              afull
);

  import fifo_pkg::*;

  logic wr_vld;
  ptr_t wr_ptr;
  ptr_t wr_ptr_nxt;
  ptr_t wr_used_nxt;

  // A write while full is dropped without notice
  assign wr_vld = wr_en & ~full;

  always_comb begin
    if (wr_vld) begin
      wr_ptr_nxt = wr_ptr + ptr_t'(1);
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  // Wraps modulo twice the depth, which is exactly what the extra pointer bit gives
  assign wr_used_nxt = wr_ptr_nxt - rd_ptr_bin;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= bin2gray(wr_ptr_nxt);
    end
  end

  // The read pointer seen here is stale, so the flags can only err toward full
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_used_nxt == ptr_t'(FIFO_DEPTH));
      afull <= (wr_used_nxt >= ptr_t'(FIFO_AFULL));
    end
  end

  // The RAM stores the word at the same edge that moves the pointer
  always_comb begin
    ram_wr.en   = wr_vld;
    ram_wr.addr = wr_ptr[ADDR_WIDTH-1:0];
    ram_wr.data = wr_data;
  end

endmodule

// File: rd_ptr_ctrl.sv
module rd_ptr_ctrl (
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_en,
  input  fifo_pkg::ptr_t    wr_ptr_bin,
  output fifo_pkg::ptr_t    rd_ptr_gray,
  output fifo_pkg::ram_rd_t ram_rd,
  output logic              empty,
  output logic              aempty
);

  import fifo_pkg::*;

  logic rd_vld;
  ptr_t rd_ptr;
  ptr_t rd_ptr_nxt;
  ptr_t rd_used_nxt;

  // A read while empty is ignored and rd_data keeps its old word
  assign rd_vld = rd_en & ~empty;

  always_comb begin
    if (rd_vld) begin
      rd_ptr_nxt = rd_ptr + ptr_t'(1);
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  assign rd_used_nxt = wr_ptr_bin - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= bin2gray(rd_ptr_nxt);
    end
  end

  // Stale write pointer means these can only err toward empty
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_used_nxt == '0);
      aempty <= (rd_used_nxt <= ptr_t'(FIFO_AEMPTY));
    end
  end

  // Address comes from the current pointer, the RAM registers the word
  always_comb begin
    ram_rd.en   = rd_vld;
    ram_rd.addr = rd_ptr[ADDR_WIDTH-1:0];
  end

endmodule

// File: async_fifo.sv
module async_fifo (
  input  logic            wr_clk,
  input  logic            wr_rst_n,
  input  logic            wr_en,
  input  fifo_pkg::data_t wr_data,
  output logic            full,
  output logic            afull,
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            rd_en,
  output fifo_pkg::data_t rd_data,
  output logic            empty,
  output logic            aempty
);

  import fifo_pkg::*;

  ram_wr_t ram_wr;
  ram_rd_t ram_rd;

  ptr_t wr_ptr_gray;
  ptr_t rd_ptr_gray;

  // Binary copies of the foreign pointers, each in its destination domain
  ptr_t wr_ptr_bin_rd;
  ptr_t rd_ptr_bin_wr;

  wr_ptr_ctrl u_wr_ptr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .rd_ptr_bin  (rd_ptr_bin_wr),
    .wr_ptr_gray (wr_ptr_gray),
    .ram_wr      (ram_wr),
    .full        (full),
    .afull       (afull)
  );

  rd_ptr_ctrl u_rd_ptr_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_bin  (wr_ptr_bin_rd),
    .rd_ptr_gray (rd_ptr_gray),
    .ram_rd      (ram_rd),
    .empty       (empty),
    .aempty      (aempty)
  );

  // Read pointer into the write domain
  gray_ptr_sync u_rd2wr_sync (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_ptr_gray),
    .bin_out (rd_ptr_bin_wr)
  );

  // Write pointer into the read domain
  gray_ptr_sync u_wr2rd_sync (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_ptr_gray),
    .bin_out (wr_ptr_bin_rd)
  );

  dual_port_ram u_dual_port_ram (
    .wr_clk   (wr_clk),
    .wr       (ram_wr),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd       (ram_rd),
    .rd_data  (rd_data)
  );

endmodule

// File: tb_async_fifo.sv
module tb_async_fifo;

  import fifo_pkg::*;

  logic  wr_clk;
  logic  wr_rst_n;
  logic  wr_en;
  data_t wr_data;
  logic  full;
  logic  afull;
  logic  rd_clk;
  logic  rd_rst_n;
  logic  rd_en;
  data_t rd_data;
  logic  empty;
  logic  aempty;

  int          fd;
  logic [7:0]  code;
  logic [31:0] val;
  logic [31:0] rng_state;
  logic        trace_eof;
  logic        trace_done;
  logic        aborted;
  int          test_num;
  int          test_errors;
  int          pass_count;
  int          fail_count;

  async_fifo u_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .aempty   (aempty)
  );

  // The 14 and 20 unit periods keep the two domains drifting against each other
  initial begin
    rd_clk = 1'b0;
    forever #10 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #7 wr_clk = ~wr_clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Returns the next code letter, skipping blanks and lines that start with #
  task automatic read_code(output logic [7:0] c, output logic eof);
    int   ch;
    logic in_comment;
    logic found;
    c = 8'h00;
    eof = 1'b0;
    in_comment = 1'b0;
    found = 1'b0;
    while (!found && !eof) begin
      ch = $fgetc(fd);
      if (ch < 0) begin
        eof = 1'b1;
      end else if (in_comment) begin
        if (ch == 10) in_comment = 1'b0;
      end else if (ch == 35) begin
        in_comment = 1'b1;
      end else if (ch > 32) begin
        c = ch[7:0];
        found = 1'b1;
      end
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    assert (actual === expected) else begin
      $display("[FAIL] %s expected %h got %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic write_word(input data_t d);
    int waited;
    rng_state = lcg_next(rng_state);
    repeat (rng_state[17:16]) @(posedge wr_clk);
    @(posedge wr_clk);
    #2;
    waited = 0;
    while (full && waited < 200) begin
      @(posedge wr_clk);
      #2;
      waited++;
    end
    if (full) begin
      $display("Write of %h timed out after 200 cycles waiting for full to fall", d);
      test_errors++;
      aborted = 1'b1;
    end else begin
      wr_en = 1'b1;
      wr_data = d;
      @(posedge wr_clk);
      #2;
      wr_en = 1'b0;
    end
  endtask

  // A write offered while full must leave the FIFO contents untouched
  task automatic write_while_full(input data_t d);
    @(posedge wr_clk);
    #2;
    check_flag("full", full, 1'b1);
    wr_en = 1'b1;
    wr_data = d;
    @(posedge wr_clk);
    #2;
    wr_en = 1'b0;
  endtask

  task automatic read_word(input data_t expected);
    int waited;
    rng_state = lcg_next(rng_state);
    repeat (rng_state[17:16]) @(posedge rd_clk);
    @(posedge rd_clk);
    #2;
    waited = 0;
    while (empty && waited < 200) begin
      @(posedge rd_clk);
      #2;
      waited++;
    end
    if (empty) begin
      $display("Read of %h timed out after 200 cycles waiting for empty to fall", expected);
      test_errors++;
      aborted = 1'b1;
    end else begin
      rd_en = 1'b1;
      @(posedge rd_clk);
      #2;
      rd_en = 1'b0;
      assert (rd_data === expected) else begin
        $display("[FAIL] rd_data expected %h got %h", expected, rd_data);
        test_errors++;
      end
    end
  endtask

  task automatic settle(input logic [31:0] cycles);
    repeat (cycles) @(posedge rd_clk);
    repeat (cycles) @(posedge wr_clk);
  endtask

  task automatic end_test();
    test_num++;
    if (test_errors == 0) begin
      pass_count++;
      $display("Test %0d finished with no errors", test_num);
    end else begin
      fail_count++;
      $display("Test %0d finished with %0d errors", test_num, test_errors);
    end
    test_errors = 0;
  endtask

  // Write side flags are sampled after wr_clk, read side flags after rd_clk
  task automatic apply_step(input logic [7:0] c, input logic [31:0] v);
    case (c)
      "W": write_word(v[DATA_WIDTH-1:0]);
      "D": write_while_full(v[DATA_WIDTH-1:0]);
      "R": read_word(v[DATA_WIDTH-1:0]);
      "S": settle(v);
      "F": begin
        @(posedge wr_clk);
        #2;
        check_flag("full", full, v[0]);
      end
      "A": begin
        @(posedge wr_clk);
        #2;
        check_flag("afull", afull, v[0]);
      end
      "E": begin
        @(posedge rd_clk);
        #2;
        check_flag("empty", empty, v[0]);
      end
      "M": begin
        @(posedge rd_clk);
        #2;
        check_flag("aempty", aempty, v[0]);
      end
      "T": end_test();
      default: begin
        $display("The trace holds an unknown code %c", c);
        test_errors++;
      end
    endcase
  endtask

  initial begin
    wr_en = 1'b0;
    wr_data = '0;
    rd_en = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    rng_state = 32'h3f38875c;
    trace_done = 1'b0;
    aborted = 1'b0;
    test_num = 0;
    test_errors = 0;
    pass_count = 0;
    fail_count = 0;
    repeat (2) @(posedge rd_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    fd = $fopen("async_fifo_trace.txt", "r");
    if (fd == 0) begin
      $display("The trace file async_fifo_trace.txt could not be opened");
      fail_count++;
      trace_done = 1'b1;
    end
    while (!trace_done && !aborted) begin
      read_code(code, trace_eof);
      if (trace_eof) begin
        trace_done = 1'b1;
      end else if ($fscanf(fd, "%h", val) != 1) begin
        $display("The trace line with code %c has no hex value", code);
        test_errors++;
        aborted = 1'b1;
      end else begin
        apply_step(code, val);
      end
    end
    if (fd != 0) $fclose(fd);
    // A test left open at the end of the trace still counts
    if (aborted || test_errors > 0) end_test();
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && test_num > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: async_fifo_trace.txt
# Code and hex value per line: W write, D write while full, R read and expect, S settle cycles
# F full, A afull, E empty, M aempty take 0 or 1; T ends a test and its value is unused
# Reset state
S 4
F 0
A 0
E 1
M 1
T 0
# Burst order
W 11
W 22
W 33
W 44
R 11
R 22
R 33
R 44
T 0
# Full and a dropped write
W a0
W a1
W a2
W a3
W a4
W a5
W a6
W a7
W a8
W a9
W aa
W ab
W ac
W ad
W ae
W af
D ee
S 4
F 1
A 1
R a0
R a1
R a2
R a3
R a4
R a5
R a6
R a7
R a8
R a9
R aa
R ab
R ac
R ad
R ae
R af
S 4
E 1
T 0
# Thresholds at occupancy 2, 3, 13 and 14
W c0
W c1
S 4
M 1
A 0
W c2
S 4
M 0
W c3
W c4
W c5
W c6
W c7
W c8
W c9
W ca
W cb
W cc
S 4
A 0
W cd
S 4
A 1
F 0
T 0
# Concurrent traffic draining the threshold words
R c0
R c1
W d0
R c2
R c3
W d1
R c4
W d2
R c5
R c6
W d3
R c7
R c8
R c9
R ca
R cb
R cc
R cd
R d0
R d1
R d2
R d3
S 4
E 1
T 0

// File: all.f
fifo_pkg.sv
dual_port_ram.sv
gray_ptr_sync.sv
wr_ptr_ctrl.sv
rd_ptr_ctrl.sv
async_fifo.sv
tb_async_fifo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the async FIFO testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f all.f --top-module tb_async_fifo \
  -Mdir obj_dir -o tb_async_fifo
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_async_fifo > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi
